//--- sources.f
vc_pkg.sv
lr_frame_fsm.sv
slot_counter.sv
serial_rx.sv
serial_tx.sv
reorder_buffer.sv
voice_path_top.sv
tb_checker.sv
tb_top.sv

//--- Makefile
TOP := tb_top
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_top.sv
module tb_top;

    localparam int CLK_PERIOD     = 8;
    localparam int NUM_FRAMES     = 256;
    localparam int HALF_CYCLES    = 20;
    localparam int GAP_CYCLES     = HALF_CYCLES - 1 - vc_pkg::SAMPLE_W;
    localparam int RUN_CYCLES     = NUM_FRAMES * 2 * HALF_CYCLES;
    // run length plus margin for reset and the tail
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 760;

    logic        clk = 1'b0;
    logic        NRST;
    logic        lrck;
    logic        adc_dat;
    logic        dac_dat;

    logic [15:0] lfsr;
    int          cycle_count;
    int          word_errors;
    int          stray_errors;
    int          words_checked;
    int          neg_words;

    always #(CLK_PERIOD / 2) clk = ~clk;

    voice_path_top dut0 (
        .clk     (clk),
        .NRST    (NRST),
        .lrck    (lrck),
        .adc_dat (adc_dat),
        .dac_dat (dac_dat)
    );

    tb_checker chk0 (
        .clk           (clk),
        .NRST          (NRST),
        .lrck          (lrck),
        .adc_dat       (adc_dat),
        .dac_dat       (dac_dat),
        .word_errors   (word_errors),
        .stray_errors  (stray_errors),
        .words_checked (words_checked),
        .neg_words     (neg_words)
    );

    // ========================================
    // stimulus helpers
    // ========================================
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_word(output vc_pkg::sample_t word);
        word = '0;
        for (int i = 0; i < vc_pkg::SAMPLE_W; i++) begin
            lfsr = lfsr_next(lfsr);
            word = {word[vc_pkg::SAMPLE_W-2:0], lfsr[0]};
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // lrck edge, 16 bits MSB first, then the gap
    task automatic send_half(input logic level);
        vc_pkg::sample_t word;
        draw_word(word);
        tick();
        lrck    = level;
        adc_dat = 1'b0;
        for (int b = vc_pkg::SAMPLE_W - 1; b >= 0; b--) begin
            tick();
            adc_dat = word[b];
        end
        for (int g = 0; g < GAP_CYCLES; g++) begin
            tick();
            adc_dat = 1'b0;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        NRST    = 1'b0;
        lrck    = 1'b1;
        adc_dat = 1'b0;
        lfsr    = 16'd95;
        tick();
        tick();
        NRST = 1'b1;
        tick();
        tick();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_half(1'b0);
            send_half(1'b1);
        end

        while (words_checked < 2 * NUM_FRAMES) begin
            @(posedge clk);
        end

        if (neg_words == 0) begin
            $display("no negative sample reached the output");
        end
        $display("word errors %0d, stray bit errors %0d, words checked %0d",
                 word_errors, stray_errors, words_checked);
        if ((word_errors == 0) && (stray_errors == 0) && (neg_words > 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // ========================================
    // watchdog
    // ========================================
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("run did not finish within %0d cycles, %0d of %0d words were checked",
                 TIMEOUT_CYCLES, words_checked, 2 * NUM_FRAMES);
        $display("word errors %0d, stray bit errors %0d, words checked %0d",
                 word_errors, stray_errors, words_checked);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- tb_checker.sv
module tb_checker (
    input  logic clk,
    input  logic NRST,
    input  logic lrck,
    input  logic adc_dat,
    input  logic dac_dat,
    output int   word_errors,
    output int   stray_errors,
    output int   words_checked,
    output int   neg_words
);

    localparam int NUM_FRAMES = 256;
    localparam int LAST_SLOT  = vc_pkg::SAMPLE_W;

    // left words as they went into the codec port, one per frame
    vc_pkg::sample_t sent_words [0:NUM_FRAMES-1];

    logic            lrck_prev;
    logic            started;
    logic            in_left;
    int              frame;
    int              slot;
    vc_pkg::sample_t in_word;
    vc_pkg::sample_t out_word;

    // ========================================
    // reference model
    // ========================================
    // three base-4 digits, swapped end for end
    function automatic int reversed_pos(input int pos);
        int lo;
        int mid;
        int hi;
        lo  = pos % 4;
        mid = (pos / 4) % 4;
        hi  = pos / 16;
        return lo * 16 + mid * 4 + hi;
    endfunction

    // silent for the first block, then the previous block reordered
    function automatic vc_pkg::sample_t expected_word(input int n);
        int block_base;
        int src;
        if (n < vc_pkg::BLOCK_LEN) begin
            return '0;
        end
        block_base = (n / vc_pkg::BLOCK_LEN - 1) * vc_pkg::BLOCK_LEN;
        src        = block_base + reversed_pos(n % vc_pkg::BLOCK_LEN);
        return sent_words[src];
    endfunction

    task automatic finish_word();
        vc_pkg::sample_t expected;
        if (in_left && (frame < NUM_FRAMES)) begin
            sent_words[frame] = in_word;
        end
        expected      = expected_word(frame);
        words_checked = words_checked + 1;
        if ((frame >= vc_pkg::BLOCK_LEN) && expected[vc_pkg::SAMPLE_W-1]) begin
            neg_words = neg_words + 1;
        end
        if (out_word !== expected) begin
            word_errors = word_errors + 1;
            $display("error dac_dat frame %0d %s word: expected %04h, got %04h",
                     frame, in_left ? "left" : "right", expected, out_word);
        end
    endtask

    // ========================================
    // slot tracking, sampled mid-cycle
    // ========================================
    always @(negedge clk) begin
        if (!NRST) begin
            lrck_prev     = lrck;
            started       = 1'b0;
            in_left       = 1'b0;
            frame         = 0;
            slot          = 0;
            in_word       = '0;
            out_word      = '0;
            word_errors   = 0;
            stray_errors  = 0;
            words_checked = 0;
            neg_words     = 0;
        end else begin
            if (lrck !== lrck_prev) begin
                slot = 0;
                if (!lrck) begin
                    // falling edge opens a new frame
                    if (started) begin
                        frame = frame + 1;
                    end
                    started = 1'b1;
                    in_left = 1'b1;
                end else begin
                    in_left = 1'b0;
                end
            end else begin
                slot = slot + 1;
            end
            lrck_prev = lrck;

            if (started && (slot >= 1) && (slot <= LAST_SLOT)) begin
                if (in_left) begin
                    in_word = {in_word[vc_pkg::SAMPLE_W-2:0], adc_dat};
                end
                out_word = {out_word[vc_pkg::SAMPLE_W-2:0], dac_dat};
                if (slot == LAST_SLOT) begin
                    finish_word();
                end
            end else if (dac_dat !== 1'b0) begin
                stray_errors = stray_errors + 1;
                $display("dac_dat was not low outside a data slot in frame %0d, slot %0d",
                         frame, slot);
            end
        end
    end

endmodule

//--- voice_path_top.sv
module voice_path_top (
    input  logic clk,
    input  logic NRST,
    input  logic lrck,
    input  logic adc_dat,
    output logic dac_dat
);

    vc_pkg::frame_ctrl_t ctrl;
    logic                bit_last;
    vc_pkg::idx_t        wr_idx;
    logic                wr_bank;
    logic                primed;
    vc_pkg::sample_t     rx_sample;
    vc_pkg::sample_t     tx_word;

    // ========================================
    // framing and counters
    // ========================================
    lr_frame_fsm u_frame (
        .clk      (clk),
        .NRST     (NRST),
        .lrck     (lrck),
        .bit_last (bit_last),
        .ctrl     (ctrl)
    );

    slot_counter u_count (
        .clk      (clk),
        .NRST     (NRST),
        .ctrl     (ctrl),
        .bit_last (bit_last),
        .wr_idx   (wr_idx),
        .wr_bank  (wr_bank),
        .primed   (primed)
    );

    // ========================================
    // datapath
    // ========================================
    serial_rx u_rx (
        .clk       (clk),
        .NRST      (NRST),
        .ctrl      (ctrl),
        .adc_dat   (adc_dat),
        .rx_sample (rx_sample)
    );

    reorder_buffer u_buf (
        .clk       (clk),
        .NRST      (NRST),
        .ctrl      (ctrl),
        .rx_sample (rx_sample),
        .wr_idx    (wr_idx),
        .wr_bank   (wr_bank),
        .primed    (primed),
        .tx_word   (tx_word)
    );

    serial_tx u_tx (
        .clk     (clk),
        .NRST    (NRST),
        .ctrl    (ctrl),
        .tx_word (tx_word),
        .dac_dat (dac_dat)
    );

endmodule

//--- reorder_buffer.sv
module reorder_buffer (
    input  logic                clk,
    input  logic                NRST,
    input  vc_pkg::frame_ctrl_t ctrl,
    input  vc_pkg::sample_t     rx_sample,
    input  vc_pkg::idx_t        wr_idx,
    input  logic                wr_bank,
    input  logic                primed,
    output vc_pkg::sample_t     tx_word
);

    vc_pkg::sample_t mem [0:vc_pkg::NUM_BANKS-1][0:vc_pkg::BLOCK_LEN-1];
    vc_pkg::idx_t    rd_idx;

    // swap the base-4 digits end for end
    function automatic vc_pkg::idx_t digit_rev(input vc_pkg::idx_t idx);
        vc_pkg::idx_t rev;
        rev = '0;
        for (int d = 0; d < vc_pkg::NUM_DIGITS; d++) begin
            rev[d*vc_pkg::DIGIT_W +: vc_pkg::DIGIT_W] =
                idx[(vc_pkg::NUM_DIGITS-1-d)*vc_pkg::DIGIT_W +: vc_pkg::DIGIT_W];
        end
        return rev;
    endfunction

    // ========================================
    // write side, arrival order
    // ========================================
    always_ff @(posedge clk) begin
        if (ctrl.left_done) begin
            mem[wr_bank][wr_idx] <= rx_sample;
        end
    end

    // ========================================
    // read side, digit-reversed
    // ========================================
    // read address moves with wr_idx, always its reversed value
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            rd_idx <= '0;
        end else if (ctrl.left_done) begin
            rd_idx <= digit_rev(wr_idx + vc_pkg::idx_t'(1));
        end
    end

    // previous block from the other bank, silent until one block is in
    assign tx_word = primed ? mem[~wr_bank][rd_idx] : '0;

endmodule

//--- serial_tx.sv
module serial_tx (
    input  logic                clk,
    input  logic                NRST,
    input  vc_pkg::frame_ctrl_t ctrl,
    input  vc_pkg::sample_t     tx_word,
    output logic                dac_dat
);

    vc_pkg::sample_t shift_q;
    logic            right_next;

    // marks that the coming word start belongs to the right channel
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            right_next <= 1'b0;
        end else if (ctrl.left_done) begin
            right_next <= 1'b1;
        end else if (ctrl.word_start) begin
            right_next <= 1'b0;
        end
    end

    // the register rotates, so after 16 bits it holds the word again
    // and the right slot replays the left word unchanged
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            shift_q <= '0;
        end else if (ctrl.word_start && !right_next) begin
            shift_q <= tx_word;
        end else if (ctrl.bit_en) begin
            shift_q <= {shift_q[vc_pkg::SAMPLE_W-2:0], shift_q[vc_pkg::SAMPLE_W-1]};
        end
    end

    // quiet outside data slots
    assign dac_dat = ctrl.bit_en & shift_q[vc_pkg::SAMPLE_W-1];

endmodule

//--- serial_rx.sv
module serial_rx (
    input  logic                clk,
    input  logic                NRST,
    input  vc_pkg::frame_ctrl_t ctrl,
    input  logic                adc_dat,
    output vc_pkg::sample_t     rx_sample
);

    vc_pkg::sample_t shift_q;

    // MSB arrives first, left slots only
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            shift_q <= '0;
        end else if (ctrl.capture_en) begin
            shift_q <= {shift_q[vc_pkg::SAMPLE_W-2:0], adc_dat};
        end
    end

    // stays put through the gap and the right word
    assign rx_sample = shift_q;

endmodule

//--- slot_counter.sv
module slot_counter (
    input  logic                clk,
    input  logic                NRST,
    input  vc_pkg::frame_ctrl_t ctrl,
    output logic                bit_last,
    output vc_pkg::idx_t        wr_idx,
    output logic                wr_bank,
    output logic                primed
);

    vc_pkg::bit_cnt_t bit_cnt;

    // bit slot within the current word
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            bit_cnt <= '0;
        end else if (ctrl.word_start) begin
            bit_cnt <= '0;
        end else if (ctrl.bit_en) begin
            bit_cnt <= bit_cnt + vc_pkg::bit_cnt_t'(1);
        end
    end

    assign bit_last = (bit_cnt == vc_pkg::bit_cnt_t'(vc_pkg::LAST_BIT));

    // sample index across the block, bank flips on every wrap
    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            wr_idx  <= '0;
            wr_bank <= 1'b0;
            primed  <= 1'b0;
        end else if (ctrl.left_done) begin
            wr_idx <= wr_idx + vc_pkg::idx_t'(1);
            if (wr_idx == vc_pkg::idx_t'(vc_pkg::BLOCK_LEN - 1)) begin
                wr_bank <= ~wr_bank;
                // first full block is in, playback may start
                primed  <= 1'b1;
            end
        end
    end

endmodule

//--- lr_frame_fsm.sv
module lr_frame_fsm (
    input  logic                clk,
    input  logic                NRST,
    input  logic                lrck,
    input  logic                bit_last,
    output vc_pkg::frame_ctrl_t ctrl
);

    vc_pkg::frame_state_e state;
    vc_pkg::frame_state_e state_next;
    logic                 lrck_q;
    logic                 lrck_fall;
    logic                 lrck_rise;
    logic                 left_done_q;

    // falling edge opens the left word, rising edge the right one
    assign lrck_fall = lrck_q & ~lrck;
    assign lrck_rise = ~lrck_q & lrck;

    always_ff @(posedge clk or negedge NRST) begin
        if (!NRST) begin
            lrck_q      <= 1'b0;
            state       <= vc_pkg::wait_frame;
            left_done_q <= 1'b0;
        end else begin
            lrck_q      <= lrck;
            state       <= state_next;
            // one pulse right after the 16th left bit
            left_done_q <= (state == vc_pkg::left_bits) && bit_last;
        end
    end

    // ========================================
    // next state
    // ========================================
    always_comb begin
        state_next = state;
        if (lrck_fall) begin
            state_next = vc_pkg::left_bits;
        end else if (lrck_rise && (state != vc_pkg::wait_frame)) begin
            state_next = vc_pkg::right_bits;
        end else begin
            case (state)
                vc_pkg::left_bits: begin
                    if (bit_last) begin
                        state_next = vc_pkg::left_gap;
                    end
                end
                vc_pkg::right_bits: begin
                    if (bit_last) begin
                        state_next = vc_pkg::right_gap;
                    end
                end
                default: begin
                    state_next = state;
                end
            endcase
        end
    end

    // ========================================
    // strobes
    // ========================================
    always_comb begin
        // a rising edge before the first left word is ignored
        ctrl.word_start = lrck_fall | (lrck_rise & (state != vc_pkg::wait_frame));
        ctrl.bit_en     = (state == vc_pkg::left_bits) | (state == vc_pkg::right_bits);
        ctrl.capture_en = (state == vc_pkg::left_bits);
        ctrl.left_done  = left_done_q;
    end

endmodule

//--- vc_pkg.sv
package vc_pkg;

    // ========================================
    // widths and block constants
    // ========================================
    localparam int SAMPLE_W   = 16;
    localparam int BLOCK_LEN  = 64;
    localparam int IDX_W      = 6;
    localparam int DIGIT_W    = 2;
    localparam int NUM_DIGITS = IDX_W / DIGIT_W;
    localparam int NUM_BANKS  = 2;
    localparam int BIT_CNT_W  = 4;
    localparam int LAST_BIT   = SAMPLE_W - 1;

    typedef logic [SAMPLE_W-1:0]  sample_t;
    typedef logic [IDX_W-1:0]     idx_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    // ========================================
    // framing
    // ========================================
    typedef enum logic [2:0] {
        wait_frame,
        left_bits,
        left_gap,
        right_bits,
        right_gap
    } frame_state_e;

    // strobes handed from the framing FSM to the datapath
    typedef struct packed {
        logic word_start;
        logic bit_en;
        logic capture_en;
        logic left_done;
    } frame_ctrl_t;

endpackage
